//--- logic/ecc_pkg.sv
package ecc_pkg;

    localparam int DATA_WIDTH   = 122;
    localparam int PARITY_WIDTH = 9;

    typedef logic [DATA_WIDTH-1:0]              data_t;
    typedef logic [PARITY_WIDTH-1:0]            parity_t;
    typedef logic [PARITY_WIDTH+DATA_WIDTH-1:0] codeword_t;   // check bits above the data

    // data bits fill the codeword positions from 3 upward that are not powers of two,
    // so bits 0 to 119 sit below 128 and bits 120 and 121 land on 129 and 130
    function automatic parity_t data_column(input int idx);
        logic [PARITY_WIDTH-2:0] pos;
        int                      rank;
        int                      p;
        pos  = '0;
        rank = 0;
        for (p = 3; p < 2 ** (PARITY_WIDTH - 1); p++) begin
            if ((p & (p - 1)) != 0) begin   // power-of-two positions belong to check bits
                if (rank == idx) begin
                    pos = p[PARITY_WIDTH-2:0];
                end
                rank++;
            end
        end
        // top bit makes every column odd weight, which keeps double errors
        // apart from single ones
        return {~^pos, pos};
    endfunction

    function automatic parity_t ecc_encode(input data_t data);
        parity_t p;
        int      i;
        p = '0;
        for (i = 0; i < DATA_WIDTH; i++) begin
            if (data[i]) begin
                p = p ^ data_column(i);
            end
        end
        return p;
    endfunction

endpackage

//--- logic/ecc_encoder.sv
`timescale 1ns/100ps

module ecc_encoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  logic               in_bypass,
    input  ecc_pkg::data_t     in_data,
    input  ecc_pkg::codeword_t in_flip,
    output logic               in_ready,
    output logic               enc_valid,
    output logic               enc_bypass,
    output ecc_pkg::codeword_t enc_codeword,
    input  logic               enc_ready
);

    ecc_pkg::codeword_t clean_codeword;
    logic               accept;

    assign clean_codeword = {ecc_pkg::ecc_encode(in_data), in_data};

    // the stage takes a new word whenever it is empty or being drained
    assign in_ready = !enc_valid || enc_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            enc_valid <= 1'b0;
        end else if (in_ready) begin
            enc_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            enc_codeword <= clean_codeword ^ in_flip;   // flip mask models a storage fault
            enc_bypass   <= in_bypass;
        end
    end

endmodule

//--- logic/codeword_fifo.sv
`timescale 1ns/100ps

module codeword_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               enc_valid,
    input  logic               enc_bypass,
    input  ecc_pkg::codeword_t enc_codeword,
    output logic               enc_ready,
    output logic               fifo_valid,
    output logic               fifo_bypass,
    output ecc_pkg::codeword_t fifo_codeword,
    input  logic               fifo_ready
);

    localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_WIDTH-1:0]   LAST_SLOT  = PTR_WIDTH'(FIFO_DEPTH - 1);
    localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(FIFO_DEPTH);

    ecc_pkg::codeword_t     code_mem   [FIFO_DEPTH];
    logic                   bypass_mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   wr_en;
    logic                   rd_en;

    assign enc_ready  = (count != FULL_COUNT);
    assign fifo_valid = (count != '0);
    assign wr_en      = enc_valid && enc_ready;
    assign rd_en      = fifo_valid && fifo_ready;

    // read side looks at the head slot only, a word written this cycle shows up next cycle
    assign fifo_codeword = code_mem[rd_ptr];
    assign fifo_bypass   = bypass_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            code_mem[wr_ptr]   <= enc_codeword;
            bypass_mem[wr_ptr] <= enc_bypass;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither leave occupancy as is
            endcase
        end
    end

endmodule

//--- logic/ecc_decoder.sv
`timescale 1ns/100ps

module ecc_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               fifo_valid,
    input  logic               fifo_bypass,
    input  ecc_pkg::codeword_t fifo_codeword,
    output logic               fifo_ready,
    output logic               out_valid,
    output ecc_pkg::data_t     out_data,
    output logic               out_sbit_err,
    output logic               out_dbit_err,
    input  logic               out_ready
);

    typedef enum logic [1:0] {
        SYN_CLEAN,
        SYN_DATA_SINGLE,
        SYN_CHECK_SINGLE,
        SYN_DOUBLE
    } syn_class_t;

    ecc_pkg::data_t   stored_data;
    ecc_pkg::parity_t stored_check;
    ecc_pkg::parity_t syndrome;
    ecc_pkg::data_t   fix_mask;
    syn_class_t       syn_class;
    logic             load;

    assign stored_data  = fifo_codeword[ecc_pkg::DATA_WIDTH-1:0];
    assign stored_check = fifo_codeword[ecc_pkg::DATA_WIDTH +: ecc_pkg::PARITY_WIDTH];
    assign syndrome     = ecc_pkg::ecc_encode(stored_data) ^ stored_check;

    // each data bit compares the syndrome against its own fixed column
    for (genvar i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin : g_fix
        localparam ecc_pkg::parity_t COLUMN = ecc_pkg::data_column(i);
        assign fix_mask[i] = (syndrome == COLUMN);
    end

    always_comb begin
        if (syndrome == '0) begin
            syn_class = SYN_CLEAN;
        end else if (|fix_mask) begin
            syn_class = SYN_DATA_SINGLE;
        end else if ($onehot(syndrome)) begin
            syn_class = SYN_CHECK_SINGLE;   // a lone check bit flipped, data is intact
        end else begin
            syn_class = SYN_DOUBLE;
        end
    end

    assign fifo_ready = !out_valid || out_ready;
    assign load       = fifo_valid && fifo_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            out_sbit_err <= 1'b0;
            out_dbit_err <= 1'b0;
        end else begin
            if (fifo_ready) begin
                out_valid <= fifo_valid;
            end
            if (load) begin
                out_sbit_err <= !fifo_bypass &&
                                (syn_class == SYN_DATA_SINGLE ||
                                 syn_class == SYN_CHECK_SINGLE);
                out_dbit_err <= !fifo_bypass && (syn_class == SYN_DOUBLE);
            end
        end
    end

    // mask is all zero unless the syndrome hit a data column
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= fifo_bypass ? stored_data : stored_data ^ fix_mask;
        end
    end

endmodule

//--- logic/ecc_top.sv
`timescale 1ns/100ps

module ecc_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  ecc_pkg::data_t     in_data,
    input  ecc_pkg::codeword_t in_flip,
    input  logic               in_bypass,
    output logic               out_valid,
    input  logic               out_ready,
    output ecc_pkg::data_t     out_data,
    output logic               out_sbit_err,
    output logic               out_dbit_err
);

    logic               enc_valid;
    logic               enc_ready;
    logic               enc_bypass;
    ecc_pkg::codeword_t enc_codeword;

    logic               fifo_valid;
    logic               fifo_ready;
    logic               fifo_bypass;
    ecc_pkg::codeword_t fifo_codeword;

    // producer side, faults are injected here before the word is stored
    ecc_encoder u_encoder (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_bypass    (in_bypass),
        .in_data      (in_data),
        .in_flip      (in_flip),
        .in_ready     (in_ready),
        .enc_valid    (enc_valid),
        .enc_bypass   (enc_bypass),
        .enc_codeword (enc_codeword),
        .enc_ready    (enc_ready)
    );

    codeword_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk           (clk),
        .rst           (rst),
        .enc_valid     (enc_valid),
        .enc_bypass    (enc_bypass),
        .enc_codeword  (enc_codeword),
        .enc_ready     (enc_ready),
        .fifo_valid    (fifo_valid),
        .fifo_bypass   (fifo_bypass),
        .fifo_codeword (fifo_codeword),
        .fifo_ready    (fifo_ready)
    );

    ecc_decoder u_decoder (
        .clk           (clk),
        .rst           (rst),
        .fifo_valid    (fifo_valid),
        .fifo_bypass   (fifo_bypass),
        .fifo_codeword (fifo_codeword),
        .fifo_ready    (fifo_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_sbit_err  (out_sbit_err),
        .out_dbit_err  (out_dbit_err),
        .out_ready     (out_ready)
    );

endmodule

//--- bench/ecc_checker.sv
`timescale 1ns/100ps

module ecc_checker (
    input logic           clk,
    input logic           rst,
    input logic           in_valid,
    input logic           in_ready,
    input ecc_pkg::data_t in_data,
    input logic           out_valid,
    input logic           out_ready,
    input ecc_pkg::data_t out_data,
    input logic           out_sbit_err,
    input logic           out_dbit_err
);

    // reset clears the output stage and it stays empty on the first cycle after release
    a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high during reset or on the cycle after it");

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("output word changed or dropped while out_ready was low");

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(out_sbit_err && out_dbit_err))
        else $error("single and double error flags high together");

    a_in_hold: assert property (@(posedge clk) disable iff (rst)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_data)))
        else $error("input word changed or dropped while in_ready was low");

endmodule

bind ecc_top ecc_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_data      (in_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_sbit_err (out_sbit_err),
    .out_dbit_err (out_dbit_err)
);

//--- include/ecc_tb_model.svh
`ifndef ECC_TB_MODEL_SVH
`define ECC_TB_MODEL_SVH

typedef ecc_pkg::parity_t column_table_t [ecc_pkg::DATA_WIDTH];

// walk positions upward and step over every position with a single bit set
function automatic void build_columns(output column_table_t cols);
    int pos;
    int i;
    pos = 3;
    for (i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
        while ($countones(pos) == 1) begin
            pos++;
        end
        cols[i] = {($countones(pos) % 2 == 0), pos[7:0]};
        pos++;
    end
endfunction

function automatic ecc_pkg::parity_t column_parity(input column_table_t cols,
                                                   input ecc_pkg::data_t data);
    ecc_pkg::parity_t p;
    int               i;
    p = '0;
    for (i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
        if (data[i]) begin
            p = p ^ cols[i];
        end
    end
    return p;
endfunction

function automatic void predict_result(input  column_table_t      cols,
                                       input  ecc_pkg::data_t     data,
                                       input  ecc_pkg::codeword_t flip,
                                       input  logic               bypass,
                                       output ecc_pkg::data_t     exp_data,
                                       output logic               exp_sbit,
                                       output logic               exp_dbit);
    ecc_pkg::codeword_t stored;
    ecc_pkg::data_t     raw;
    ecc_pkg::parity_t   syn;
    int                 i;
    stored   = {column_parity(cols, data), data} ^ flip;
    raw      = stored[ecc_pkg::DATA_WIDTH-1:0];
    syn      = column_parity(cols, raw) ^ stored[ecc_pkg::DATA_WIDTH +: ecc_pkg::PARITY_WIDTH];
    exp_data = raw;
    exp_sbit = 1'b0;
    exp_dbit = 1'b0;
    if (!bypass && syn != '0) begin
        if ($countones(syn) == 1) begin
            exp_sbit = 1'b1;   // only a check bit was hit so the data passes as stored
        end else begin
            exp_dbit = 1'b1;
            for (i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
                if (cols[i] == syn) begin
                    exp_data[i] = ~raw[i];
                    exp_sbit    = 1'b1;
                    exp_dbit    = 1'b0;
                end
            end
        end
    end
endfunction

`endif

//--- bench/tb_ecc.sv
`timescale 1ns/100ps

module tb_ecc;

    `include "ecc_tb_model.svh"

    localparam int KIND_CLEAN  = 0;
    localparam int KIND_DATA   = 1;
    localparam int KIND_CHECK  = 2;
    localparam int KIND_DOUBLE = 3;
    localparam int KIND_BYPASS = 4;
    localparam int KIND_MIXED  = 5;

    localparam int TOTAL_WORDS    = 200 + 50 + 30 + 50 + 30 + 200;
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20 + 100;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    ecc_pkg::data_t     in_data;
    ecc_pkg::codeword_t in_flip;
    logic               in_bypass;
    logic               out_valid;
    logic               out_ready;
    ecc_pkg::data_t     out_data;
    logic               out_sbit_err;
    logic               out_dbit_err;

    ecc_pkg::data_t     exp_data_q  [$];
    logic               exp_sbit_q  [$];
    logic               exp_dbit_q  [$];
    bit                 exp_check_q [$];   // double faults leave the data unchecked

    column_table_t      cols;
    string              cur_test;
    bit                 bp_mode;
    int                 fail_count;
    int                 tests_passed;
    int                 tests_failed;

    ecc_top #(
        .FIFO_DEPTH (4)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .in_flip      (in_flip),
        .in_bypass    (in_bypass),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .out_sbit_err (out_sbit_err),
        .out_dbit_err (out_dbit_err)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic compare_data(input string name, input ecc_pkg::data_t exp,
                                input ecc_pkg::data_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s out_data: expected %h, actual %h", name, exp, act);
            fail_count++;
        end
    endtask

    task automatic compare_flag(input string name, input string flag, input logic exp,
                                input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %b, actual %b", name, flag, exp, act);
            fail_count++;
        end
    endtask

    task automatic check_output();
        ecc_pkg::data_t exp_d;
        logic           exp_s;
        logic           exp_db;
        bit             check_d;
        if (exp_data_q.size() == 0) begin
            $display("ERROR %s: the DUT delivered a word while none was pending", cur_test);
            fail_count++;
        end else begin
            exp_d   = exp_data_q.pop_front();
            exp_s   = exp_sbit_q.pop_front();
            exp_db  = exp_dbit_q.pop_front();
            check_d = exp_check_q.pop_front();
            if (check_d) begin
                compare_data(cur_test, exp_d, out_data);
            end
            compare_flag(cur_test, "out_sbit_err", exp_s, out_sbit_err);
            compare_flag(cur_test, "out_dbit_err", exp_db, out_dbit_err);
        end
    endtask

    // outputs only move on rising edges, so the falling edge sees the settled handshake
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            check_output();
        end
    end

    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            if (bp_mode) begin
                out_ready = $urandom_range(1, 0) != 0;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    function automatic ecc_pkg::data_t rand_data();
        return ecc_pkg::data_t'({$urandom(), $urandom(), $urandom(), $urandom()});
    endfunction

    function automatic ecc_pkg::codeword_t make_flip(input int kind);
        ecc_pkg::codeword_t flip;
        int                 a;
        int                 b;
        flip = '0;
        case (kind)
            KIND_DATA: begin
                a    = $urandom_range(ecc_pkg::DATA_WIDTH - 1, 0);
                flip = ecc_pkg::codeword_t'(1) << a;
            end
            KIND_CHECK: begin
                a    = ecc_pkg::DATA_WIDTH + $urandom_range(ecc_pkg::PARITY_WIDTH - 1, 0);
                flip = ecc_pkg::codeword_t'(1) << a;
            end
            KIND_DOUBLE: begin
                a = $urandom_range(ecc_pkg::DATA_WIDTH + ecc_pkg::PARITY_WIDTH - 1, 0);
                do begin
                    b = $urandom_range(ecc_pkg::DATA_WIDTH + ecc_pkg::PARITY_WIDTH - 1, 0);
                end while (b == a);
                flip = (ecc_pkg::codeword_t'(1) << a) | (ecc_pkg::codeword_t'(1) << b);
            end
            KIND_BYPASS: flip = ecc_pkg::codeword_t'(rand_data());   // data bits only
            default:     flip = '0;
        endcase
        return flip;
    endfunction

    // called 2 ns after an edge, returns 2 ns after the edge that took the word
    task automatic send_word(input int kind);
        ecc_pkg::data_t     data;
        ecc_pkg::codeword_t flip;
        ecc_pkg::data_t     exp_d;
        logic               exp_s;
        logic               exp_db;
        int                 k;
        k    = (kind == KIND_MIXED) ? $urandom_range(KIND_BYPASS, KIND_CLEAN) : kind;
        data = rand_data();
        flip = make_flip(k);
        predict_result(cols, data, flip, k == KIND_BYPASS, exp_d, exp_s, exp_db);
        exp_data_q.push_back(exp_d);
        exp_sbit_q.push_back(exp_s);
        exp_dbit_q.push_back(exp_db);
        exp_check_q.push_back(k != KIND_DOUBLE);
        in_data   = data;
        in_flip   = flip;
        in_bypass = (k == KIND_BYPASS);
        in_valid  = 1'b1;
        while (!in_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic run_test(input string name, input int kind, input int count, input bit bp);
        int errors_before;
        int i;
        cur_test      = name;
        errors_before = fail_count;
        bp_mode       = bp;
        for (i = 0; i < count; i++) begin
            send_word(kind);
        end
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
        #2;
        bp_mode = 1'b0;
        if (fail_count == errors_before) begin
            tests_passed++;
            $display("test %s: passed, %0d words", name, count);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d words, %0d errors", name, count,
                     fail_count - errors_before);
        end
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: words still pending after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hbacf_cb05));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        in_flip      = '0;
        in_bypass    = 1'b0;
        bp_mode      = 1'b0;
        fail_count   = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test     = "reset";
        build_columns(cols);
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        run_test("clean_words", KIND_CLEAN, 200, 1'b0);
        run_test("single_data_fault", KIND_DATA, 50, 1'b0);
        run_test("single_check_fault", KIND_CHECK, 30, 1'b0);
        run_test("double_fault", KIND_DOUBLE, 50, 1'b0);
        run_test("bypass", KIND_BYPASS, 30, 1'b0);
        run_test("back_pressure", KIND_MIXED, 200, 1'b1);

        $display("summary: %0d tests passed, %0d tests failed, %0d check failures",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+include
logic/ecc_pkg.sv
logic/ecc_encoder.sv
logic/codeword_fifo.sv
logic/ecc_decoder.sv
logic/ecc_top.sv
bench/ecc_checker.sv
bench/tb_ecc.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the ECC testbench with Verilator, the log decides pass or fail

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

# a failed build or an aborted run (assertion error) also ends up as a failure in the log
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f project.f --top-module tb_ecc -o vtb_ecc > "$LOG" 2>&1 \
    && ./obj_dir/vtb_ecc >> "$LOG" 2>&1 \
    || echo "Simulation failed" >> "$LOG"

grep -q "Simulation failed" "$LOG" \
    && { echo "result: FAIL (see $LOG)"; exit 1; } \
    || { echo "result: PASS"; exit 0; }
